// File: logic/snn_pkg.sv
`default_nettype none

package snn_pkg;

    // network size
    localparam int NUM_PIXELS   = 16;   // 4x4 image
    localparam int NUM_NEURONS  = 4;
    localparam int DATA_W       = 8;    // pixels, weights, vmem, counts
    localparam int PIX_IDX_W    = 4;
    localparam int NEUR_IDX_W   = 2;    // count word select
    localparam int WORD_W       = 32;   // apb data
    localparam int APB_ADDR_W   = 12;
    localparam int DRAIN_CYCLES = 2;    // pipeline flush before leak

    // galois lfsr, shifts right and xors taps when bit 0 falls out
    localparam logic [DATA_W-1:0] LFSR_SEED = 8'hA5;
    localparam logic [DATA_W-1:0] LFSR_TAPS = 8'hB8;

    // word addresses
    localparam logic [APB_ADDR_W-1:0] ADDR_IMAGE  = 12'h000; // 16 words, pixel in low byte
    localparam logic [APB_ADDR_W-1:0] ADDR_WEIGHT = 12'h040; // 16 words, byte j -> neuron j
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 12'h080; // bit 0 starts
    localparam logic [APB_ADDR_W-1:0] ADDR_BETA   = 12'h084;
    localparam logic [APB_ADDR_W-1:0] ADDR_THRESH = 12'h088;
    localparam logic [APB_ADDR_W-1:0] ADDR_STEPS  = 12'h08C;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h090; // {done, busy}
    localparam logic [APB_ADDR_W-1:0] ADDR_COUNT  = 12'h0A0; // 4 words

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [WORD_W-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [WORD_W-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic [DATA_W-1:0] beta;     // leak factor, /256
        logic [DATA_W-1:0] thresh;
        logic [DATA_W-1:0] steps;    // timesteps per inference
    } snn_cfg_t;

    typedef struct packed {
        logic                 valid;
        logic [PIX_IDX_W-1:0] index;
        logic                 last;  // final pixel of the timestep
    } pixel_step_t;

    typedef struct packed {
        logic                 img_we;
        logic                 wgt_we;
        logic [PIX_IDX_W-1:0] index;
        logic [WORD_W-1:0]    data;
    } mem_wr_t;

    typedef logic [NUM_NEURONS-1:0][DATA_W-1:0] weight_row_t; // one pixel's fan-out

endpackage

`default_nettype wire

// File: logic/snn_apb_regs.sv
`default_nettype none
`timescale 1ns/100ps

module snn_apb_regs (
    input  wire                                                    clk,
    input  wire                                                    rst,
    input  wire snn_pkg::apb_req_t                                 apb_req_i,
    input  wire                                                    busy_i,
    input  wire                                                    done_i,
    input  wire [snn_pkg::NUM_NEURONS-1:0][snn_pkg::DATA_W-1:0]    counts_i,
    output snn_pkg::apb_rsp_t                                      apb_rsp_o,
    output snn_pkg::mem_wr_t                                       mem_wr_o,
    output snn_pkg::snn_cfg_t                                      cfg_o,
    output logic                                                   start_o
);

    logic                              acc;      // access phase
    logic                              wr;
    logic                              rd;
    logic                              wr_ok;    // write allowed, not busy
    logic                              aligned;
    logic [snn_pkg::PIX_IDX_W-1:0]     word_idx;
    logic [snn_pkg::NEUR_IDX_W-1:0]    cnt_idx;
    logic                              hit_img;
    logic                              hit_wgt;
    logic                              hit_ctrl;
    logic                              hit_beta;
    logic                              hit_thr;
    logic                              hit_steps;
    logic                              hit_stat;
    logic                              hit_cnt;
    logic                              mapped;
    logic                              cfg_hit;  // locked while busy
    logic                              start_hit;
    logic [snn_pkg::WORD_W-1:0]        rdata;
    snn_pkg::snn_cfg_t                 cfg_q;
    logic [snn_pkg::DATA_W-1:0]        img_copy [snn_pkg::NUM_PIXELS]; // host readback copy
    logic [snn_pkg::WORD_W-1:0]        wgt_copy [snn_pkg::NUM_PIXELS];

    assign acc      = apb_req_i.psel & apb_req_i.penable;
    assign wr       = acc & apb_req_i.pwrite;
    assign rd       = acc & ~apb_req_i.pwrite;
    assign wr_ok    = wr & ~busy_i;
    assign aligned  = (apb_req_i.paddr[1:0] == 2'b00);
    assign word_idx = apb_req_i.paddr[snn_pkg::PIX_IDX_W+1:2];
    assign cnt_idx  = apb_req_i.paddr[snn_pkg::NEUR_IDX_W+1:2];

    // address decode, arrays by upper bits
    assign hit_img   = aligned & (apb_req_i.paddr[11:6] == snn_pkg::ADDR_IMAGE[11:6]);
    assign hit_wgt   = aligned & (apb_req_i.paddr[11:6] == snn_pkg::ADDR_WEIGHT[11:6]);
    assign hit_cnt   = aligned & (apb_req_i.paddr[11:4] == snn_pkg::ADDR_COUNT[11:4]);
    assign hit_ctrl  = (apb_req_i.paddr == snn_pkg::ADDR_CTRL);
    assign hit_beta  = (apb_req_i.paddr == snn_pkg::ADDR_BETA);
    assign hit_thr   = (apb_req_i.paddr == snn_pkg::ADDR_THRESH);
    assign hit_steps = (apb_req_i.paddr == snn_pkg::ADDR_STEPS);
    assign hit_stat  = (apb_req_i.paddr == snn_pkg::ADDR_STATUS);

    assign mapped  = hit_img | hit_wgt | hit_cnt | hit_ctrl | hit_beta | hit_thr
                   | hit_steps | hit_stat;
    assign cfg_hit = hit_img | hit_wgt | hit_beta | hit_thr | hit_steps;

    // start only from idle with a nonzero step count
    assign start_hit = wr & hit_ctrl & apb_req_i.pwdata[0];
    assign start_o   = start_hit & ~busy_i & (cfg_q.steps != '0);

    // memory writes go straight to the datapath stores
    assign mem_wr_o.img_we = wr_ok & hit_img;
    assign mem_wr_o.wgt_we = wr_ok & hit_wgt;
    assign mem_wr_o.index  = word_idx;
    assign mem_wr_o.data   = apb_req_i.pwdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (wr_ok) begin
            if (hit_beta)  cfg_q.beta   <= apb_req_i.pwdata[snn_pkg::DATA_W-1:0];
            if (hit_thr)   cfg_q.thresh <= apb_req_i.pwdata[snn_pkg::DATA_W-1:0];
            if (hit_steps) cfg_q.steps  <= apb_req_i.pwdata[snn_pkg::DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok & hit_img) img_copy[word_idx] <= apb_req_i.pwdata[snn_pkg::DATA_W-1:0];
        if (wr_ok & hit_wgt) wgt_copy[word_idx] <= apb_req_i.pwdata;
    end

    // readback mux, ctrl reads as zero
    always_comb begin
        rdata = '0;
        if (hit_img)        rdata[snn_pkg::DATA_W-1:0] = img_copy[word_idx];
        else if (hit_wgt)   rdata = wgt_copy[word_idx];
        else if (hit_beta)  rdata[snn_pkg::DATA_W-1:0] = cfg_q.beta;
        else if (hit_thr)   rdata[snn_pkg::DATA_W-1:0] = cfg_q.thresh;
        else if (hit_steps) rdata[snn_pkg::DATA_W-1:0] = cfg_q.steps;
        else if (hit_stat)  rdata[1:0] = {done_i, busy_i};
        else if (hit_cnt)   rdata[snn_pkg::DATA_W-1:0] = counts_i[cnt_idx];
    end

    assign apb_rsp_o.pready  = 1'b1; // no wait states
    assign apb_rsp_o.pslverr = acc & (~mapped | (wr & busy_i & cfg_hit) | (start_hit & ~start_o));
    assign apb_rsp_o.prdata  = rd ? rdata : '0;

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: logic/snn_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module snn_sequencer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start_i,
    input  wire [snn_pkg::DATA_W-1:0]    steps_i,
    output snn_pkg::pixel_step_t         step_o,
    output logic                         leak_o,
    output logic                         busy_o,
    output logic                         done_o
);

    snn_pkg::pixel_step_t        step_q;
    logic [1:0]                  drain_q;  // cycles left before leak
    logic                        leak_q;
    logic                        busy_q;
    logic                        done_q;
    logic [snn_pkg::DATA_W-1:0]  ts_q;     // finished timesteps
    logic [snn_pkg::DATA_W-1:0]  ts_next;

    assign ts_next = ts_q + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q  <= '0;
            drain_q <= '0;
            leak_q  <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            ts_q    <= '0;
        end else begin
            leak_q <= 1'b0; // single-cycle strobe
            if (start_i) begin
                step_q  <= '{valid: 1'b1, index: '0, last: 1'b0};
                drain_q <= '0;
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
                ts_q    <= '0;
            end else if (step_q.valid) begin
                // one pixel per cycle, index wraps after the last
                step_q.index <= step_q.index + 1'b1;
                step_q.last  <= (step_q.index == snn_pkg::PIX_IDX_W'(snn_pkg::NUM_PIXELS - 2));
                if (step_q.last) begin
                    step_q.valid <= 1'b0;
                    drain_q      <= 2'(snn_pkg::DRAIN_CYCLES);
                end
            end else if (drain_q != '0) begin
                drain_q <= drain_q - 1'b1;
                leak_q  <= (drain_q == 2'd1);
            end else if (leak_q) begin
                ts_q <= ts_next;
                if (ts_next == steps_i) begin
                    busy_q <= 1'b0; // counts settle on this same edge
                    done_q <= 1'b1;
                end else begin
                    step_q <= '{valid: 1'b1, index: '0, last: 1'b0};
                end
            end
        end
    end

    assign step_o = step_q;
    assign leak_o = leak_q;
    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

// File: logic/spike_encoder.sv
`default_nettype none
`timescale 1ns/100ps

module spike_encoder (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start_i,
    input  wire snn_pkg::mem_wr_t        mem_wr_i,
    input  wire snn_pkg::pixel_step_t    step_i,
    output logic                         spike_o,
    output logic                         spike_valid_o
);

    logic [snn_pkg::DATA_W-1:0] img_mem [snn_pkg::NUM_PIXELS];
    logic [snn_pkg::DATA_W-1:0] lfsr_q;
    logic [snn_pkg::DATA_W-1:0] lfsr_next;

    // galois step
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ snn_pkg::LFSR_TAPS) : (lfsr_q >> 1);

    always_ff @(posedge clk) begin
        if (mem_wr_i.img_we) begin
            img_mem[mem_wr_i.index] <= mem_wr_i.data[snn_pkg::DATA_W-1:0]; // low byte only
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= snn_pkg::LFSR_SEED;
        end else if (start_i) begin
            lfsr_q <= snn_pkg::LFSR_SEED; // same sequence every inference
        end else if (step_i.valid) begin
            lfsr_q <= lfsr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spike_valid_o <= 1'b0;
        end else begin
            spike_valid_o <= step_i.valid;
        end
    end

    // brighter pixel, more likely to fire
    always_ff @(posedge clk) begin
        if (step_i.valid) begin
            spike_o <= (lfsr_q < img_mem[step_i.index]); // value before advance
        end
    end

endmodule

`default_nettype wire

// File: logic/weight_store.sv
`default_nettype none
`timescale 1ns/100ps

module weight_store (
    input  wire                          clk,
    input  wire                          rst,
    input  wire snn_pkg::mem_wr_t        mem_wr_i,
    input  wire snn_pkg::pixel_step_t    step_i,
    output snn_pkg::weight_row_t         row_o
);

    snn_pkg::weight_row_t wgt_mem [snn_pkg::NUM_PIXELS]; // one row per pixel

    always_ff @(posedge clk) begin
        if (mem_wr_i.wgt_we) begin
            wgt_mem[mem_wr_i.index] <= mem_wr_i.data; // byte j feeds neuron j
        end
    end

    // lines up with the encoder's spike_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            row_o <= '0;
        end else if (step_i.valid) begin
            row_o <= wgt_mem[step_i.index];
        end
    end

endmodule

`default_nettype wire

// File: logic/lif_array.sv
`default_nettype none
`timescale 1ns/100ps

module lif_array (
    input  wire                                                    clk,
    input  wire                                                    rst,
    input  wire                                                    start_i,
    input  wire                                                    spike_i,
    input  wire                                                    spike_valid_i,
    input  wire snn_pkg::weight_row_t                              row_i,
    input  wire                                                    leak_i,
    input  wire [snn_pkg::DATA_W-1:0]                              beta_i,
    input  wire [snn_pkg::DATA_W-1:0]                              thresh_i,
    output logic [snn_pkg::NUM_NEURONS-1:0][snn_pkg::DATA_W-1:0]   counts_o
);

    logic [snn_pkg::DATA_W-1:0] v_q   [snn_pkg::NUM_NEURONS]; // membrane voltages
    logic [snn_pkg::DATA_W-1:0] cnt_q [snn_pkg::NUM_NEURONS]; // output spikes

    for (genvar n = 0; n < snn_pkg::NUM_NEURONS; n++) begin : g_neuron
        logic [snn_pkg::DATA_W:0]     sum;     // carry = overflow
        logic [2*snn_pkg::DATA_W-1:0] prod;
        logic [snn_pkg::DATA_W-1:0]   leaked;

        assign sum    = {1'b0, v_q[n]} + {1'b0, row_i[n]};
        assign prod   = v_q[n] * beta_i;
        assign leaked = prod[2*snn_pkg::DATA_W-1:snn_pkg::DATA_W]; // v*beta >> 8

        always_ff @(posedge clk) begin
            if (rst || start_i) begin
                v_q[n]   <= '0;
                cnt_q[n] <= '0;
            end else if (spike_valid_i && spike_i) begin
                // integrate, clamp at full scale
                v_q[n] <= sum[snn_pkg::DATA_W] ? '1 : sum[snn_pkg::DATA_W-1:0];
            end else if (leak_i) begin
                if (leaked >= thresh_i) begin
                    v_q[n] <= '0; // fire and reset
                    if (cnt_q[n] != '1) cnt_q[n] <= cnt_q[n] + 1'b1;
                end else begin
                    v_q[n] <= leaked;
                end
            end
        end

        assign counts_o[n] = cnt_q[n];
    end

endmodule

`default_nettype wire

// File: logic/snn_top.sv
`default_nettype none
`timescale 1ns/100ps

module snn_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire snn_pkg::apb_req_t       apb_req_i,
    output snn_pkg::apb_rsp_t            apb_rsp_o
);

    snn_pkg::mem_wr_t                                        mem_wr;
    snn_pkg::snn_cfg_t                                       cfg;
    snn_pkg::pixel_step_t                                    step;
    snn_pkg::weight_row_t                                    row;
    logic                                                    start;   // also clears datapath
    logic                                                    busy;
    logic                                                    done;
    logic                                                    leak;
    logic                                                    spike;
    logic                                                    spike_valid;
    logic [snn_pkg::NUM_NEURONS-1:0][snn_pkg::DATA_W-1:0]    counts;

    snn_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req_i),
        .busy_i    (busy),
        .done_i    (done),
        .counts_i  (counts),
        .apb_rsp_o (apb_rsp_o),
        .mem_wr_o  (mem_wr),
        .cfg_o     (cfg),
        .start_o   (start)
    );

    snn_sequencer u_seq (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .steps_i (cfg.steps),
        .step_o  (step),
        .leak_o  (leak),
        .busy_o  (busy),
        .done_o  (done)
    );

    // encoder and weight fetch run side by side
    spike_encoder u_enc (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .mem_wr_i      (mem_wr),
        .step_i        (step),
        .spike_o       (spike),
        .spike_valid_o (spike_valid)
    );

    weight_store u_wgt (
        .clk      (clk),
        .rst      (rst),
        .mem_wr_i (mem_wr),
        .step_i   (step),
        .row_o    (row)
    );

    lif_array u_lif (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start),
        .spike_i       (spike),
        .spike_valid_i (spike_valid),
        .row_i         (row),
        .leak_i        (leak),
        .beta_i        (cfg.beta),
        .thresh_i      (cfg.thresh),
        .counts_o      (counts)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o; // 50% duty

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
`default_nettype none
`timescale 1ns/100ps

module tb_checker #(
    parameter int SAMPLE_DLY = 2 // ns after the falling edge
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire snn_pkg::apb_req_t apb_req_i,
    input  wire snn_pkg::apb_rsp_t apb_rsp_i,
    output int                     mismatch_count_o
);

    localparam int TS_CYCLES = snn_pkg::NUM_PIXELS + 3; // pixels, drain, leak

    logic [7:0]  img [snn_pkg::NUM_PIXELS];  // mirrored host writes
    logic [31:0] wgt [snn_pkg::NUM_PIXELS];
    logic [7:0]  cnt [snn_pkg::NUM_NEURONS]; // final counts of the last run
    logic [7:0]  beta;
    logic [7:0]  thresh;
    logic [7:0]  steps;
    int          busy_left;                  // cycles until busy drops
    logic        done;
    int          errors = 0;

    assign mismatch_count_o = errors;

    task automatic flag_mismatch(input string name, input logic [11:0] addr,
                                 input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("mismatch at %0t: %s for paddr %h expected %h actual %h",
                 $time, name, addr, exp, act);
    endtask

    // whole inference at once
    task automatic run_model();
        logic [7:0]  lfsr;
        logic [7:0]  v [snn_pkg::NUM_NEURONS];
        logic [8:0]  sum;
        logic [15:0] prod;
        lfsr = snn_pkg::LFSR_SEED;
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
            v[n]   = 8'h00;
            cnt[n] = 8'h00;
        end
        for (int t = 0; t < int'(steps); t++) begin
            for (int p = 0; p < snn_pkg::NUM_PIXELS; p++) begin
                for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
                    sum = {1'b0, v[n]} + {1'b0, wgt[p][8*n +: 8]};
                    if (lfsr < img[p]) v[n] = sum[8] ? 8'hFF : sum[7:0]; // clamp
                end
                // shift right and xor the taps in when a 1 falls out
                lfsr = lfsr[0] ? ((lfsr >> 1) ^ snn_pkg::LFSR_TAPS) : (lfsr >> 1);
            end
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
                prod = 16'(v[n]) * 16'(beta);
                if (prod[15:8] >= thresh) begin
                    v[n] = 8'h00;
                    if (cnt[n] != 8'hFF) cnt[n] = cnt[n] + 8'd1;
                end else begin
                    v[n] = prod[15:8];
                end
            end
        end
    endtask

    // one model cycle ahead of the coming rising edge
    task automatic step_model();
        logic [11:0] a;
        logic        acc;
        logic        wr;
        logic        idle;
        logic        img_hit;
        logic        wgt_hit;
        logic        cnt_hit;
        logic        cfg_hit;
        logic        start_ok;
        logic        exp_err;
        logic [31:0] exp_data;
        a        = apb_req_i.paddr;
        acc      = apb_req_i.psel && apb_req_i.penable;
        wr       = acc && apb_req_i.pwrite;
        idle     = (busy_left == 0);
        img_hit  = (a[1:0] == 2'b00) && (a < snn_pkg::ADDR_WEIGHT);
        wgt_hit  = (a[1:0] == 2'b00) && (a >= snn_pkg::ADDR_WEIGHT) && (a < snn_pkg::ADDR_CTRL);
        cnt_hit  = (a[1:0] == 2'b00) && (a >= snn_pkg::ADDR_COUNT)
                 && (a < snn_pkg::ADDR_COUNT + 12'h010);
        cfg_hit  = (a == snn_pkg::ADDR_BETA) || (a == snn_pkg::ADDR_THRESH)
                 || (a == snn_pkg::ADDR_STEPS);
        start_ok = wr && (a == snn_pkg::ADDR_CTRL) && apb_req_i.pwdata[0] && idle && (steps != 0);
        exp_err  = !(img_hit || wgt_hit || cnt_hit || cfg_hit || (a == snn_pkg::ADDR_CTRL)
                 || (a == snn_pkg::ADDR_STATUS))
                 || (wr && !idle && (img_hit || wgt_hit || cfg_hit))
                 || (wr && (a == snn_pkg::ADDR_CTRL) && apb_req_i.pwdata[0] && !start_ok);
        exp_data = 32'h0;
        if (acc && !wr) begin
            if (img_hit) exp_data[7:0] = img[a[5:2]];
            else if (wgt_hit) exp_data = wgt[a[5:2]];
            else if (a == snn_pkg::ADDR_BETA) exp_data[7:0] = beta;
            else if (a == snn_pkg::ADDR_THRESH) exp_data[7:0] = thresh;
            else if (a == snn_pkg::ADDR_STEPS) exp_data[7:0] = steps;
            else if (a == snn_pkg::ADDR_STATUS) exp_data[1:0] = {done, !idle};
            else if (cnt_hit) exp_data[7:0] = cnt[a[3:2]];
        end
        if (acc && (apb_rsp_i.pready !== 1'b1))
            flag_mismatch("pready", a, 32'h1, 32'(apb_rsp_i.pready)); // no wait states
        if (acc && (apb_rsp_i.pslverr !== exp_err))
            flag_mismatch("pslverr", a, 32'(exp_err), 32'(apb_rsp_i.pslverr));
        // counts mid-run are not modeled
        if (acc && (apb_rsp_i.prdata !== exp_data) && !(cnt_hit && !wr && !idle))
            flag_mismatch("prdata", a, exp_data, apb_rsp_i.prdata);
        if (wr && idle) begin
            if (img_hit) img[a[5:2]] = apb_req_i.pwdata[7:0];
            if (wgt_hit) wgt[a[5:2]] = apb_req_i.pwdata;
            if (a == snn_pkg::ADDR_BETA) beta = apb_req_i.pwdata[7:0];
            if (a == snn_pkg::ADDR_THRESH) thresh = apb_req_i.pwdata[7:0];
            if (a == snn_pkg::ADDR_STEPS) steps = apb_req_i.pwdata[7:0];
        end
        if (!idle) begin
            busy_left--;
            if (busy_left == 0) done = 1'b1;
        end
        if (start_ok) begin
            run_model();
            busy_left = TS_CYCLES * int'(steps);
            done      = 1'b0; // new start clears done
        end
    endtask

    // inputs and responses have settled by mid low phase
    always @(negedge clk) begin
        #SAMPLE_DLY;
        if (rst) begin
            beta      = 8'h00;
            thresh    = 8'h00;
            steps     = 8'h00;
            busy_left = 0;
            done      = 1'b0;
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) cnt[n] = 8'h00;
        end else begin
            step_model();
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_top;

    localparam int RESET_CYCLES    = 10;
    localparam int SAMPLE_DLY      = 2;      // ns after the falling edge
    localparam int POLL_LIMIT      = 400;    // status reads per run
    localparam int NUM_PROGRAMS    = 20;
    localparam int WATCHDOG_CYCLES = 200000;

    wire               clk;
    logic              rst;
    snn_pkg::apb_req_t apb_req;
    snn_pkg::apb_rsp_t apb_rsp;
    int                seed;
    int                mismatches;
    int                timeouts;
    logic [31:0]       rdata;                // last read word

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk_o(clk));

    snn_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    tb_checker #(.SAMPLE_DLY(SAMPLE_DLY)) u_checker (
        .clk              (clk),
        .rst              (rst),
        .apb_req_i        (apb_req),
        .apb_rsp_i        (apb_rsp),
        .mismatch_count_o (mismatches)
    );

    // setup phase, access phase, then idle
    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] data);
        int waits;
        waits = 0;
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #SAMPLE_DLY;
        while (!apb_rsp.pready && waits < 16) begin
            @(negedge clk);
            #SAMPLE_DLY;
            waits++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("timeout at %0t: pready never rose for paddr %h", $time, addr);
        end
        rdata = apb_rsp.prdata;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic load_memories(input logic dark);
        for (int i = 0; i < snn_pkg::NUM_PIXELS; i++) begin
            // dark pixels still carry junk above the low byte
            apb_xfer(1'b1, snn_pkg::ADDR_IMAGE + 12'(4 * i),
                     $random(seed) & (dark ? 32'hFFFF_FF00 : 32'hFFFF_FFFF));
            apb_xfer(1'b1, snn_pkg::ADDR_WEIGHT + 12'(4 * i), $random(seed));
        end
    endtask

    task automatic configure(input logic [7:0] beta, input logic [7:0] thresh,
                             input logic [7:0] steps);
        apb_xfer(1'b1, snn_pkg::ADDR_BETA, {24'h0, beta});
        apb_xfer(1'b1, snn_pkg::ADDR_THRESH, {24'h0, thresh});
        apb_xfer(1'b1, snn_pkg::ADDR_STEPS, {24'h0, steps});
    endtask

    task automatic wait_idle();
        int polls;
        polls = 0;
        apb_xfer(1'b0, snn_pkg::ADDR_STATUS, 32'h0);
        while (rdata[0] && polls < POLL_LIMIT) begin
            apb_xfer(1'b0, snn_pkg::ADDR_STATUS, 32'h0);
            polls++;
        end
        if (rdata[0]) begin
            timeouts++;
            $display("timeout at %0t: busy still set after %0d status reads", $time, polls);
        end
    endtask

    task automatic read_back();
        for (int i = 0; i < snn_pkg::NUM_PIXELS; i++) begin
            apb_xfer(1'b0, snn_pkg::ADDR_IMAGE + 12'(4 * i), 32'h0);
            apb_xfer(1'b0, snn_pkg::ADDR_WEIGHT + 12'(4 * i), 32'h0);
        end
        apb_xfer(1'b0, snn_pkg::ADDR_BETA, 32'h0);
        apb_xfer(1'b0, snn_pkg::ADDR_THRESH, 32'h0);
        apb_xfer(1'b0, snn_pkg::ADDR_STEPS, 32'h0);
        apb_xfer(1'b0, snn_pkg::ADDR_CTRL, 32'h0);   // reads as zero
    endtask

    task automatic read_counts();
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
            apb_xfer(1'b0, snn_pkg::ADDR_COUNT + 12'(4 * n), $random(seed));
        end
    endtask

    task automatic run_program(input logic dark, input logic [7:0] beta,
                               input logic [7:0] thresh, input logic [7:0] steps);
        load_memories(dark);
        configure(beta, thresh, steps);
        apb_xfer(1'b1, snn_pkg::ADDR_CTRL, 32'h1);
        wait_idle();                                 // first read sees busy
        read_counts();
    endtask

    initial begin
        seed     = 32'h66e6_7324;
        timeouts = 0;
        rdata    = 32'h0;
        rst      = 1'b1;
        apb_req  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // idle readback, counts still zero from reset
        load_memories(1'b0);
        apb_xfer(1'b1, snn_pkg::ADDR_BETA, $random(seed));
        apb_xfer(1'b1, snn_pkg::ADDR_THRESH, $random(seed));
        apb_xfer(1'b1, snn_pkg::ADDR_STEPS, $random(seed));
        read_back();
        apb_xfer(1'b0, snn_pkg::ADDR_STATUS, 32'h0);
        read_counts();
        apb_xfer(1'b0, 12'h0B0, 32'h0);              // past the counts
        apb_xfer(1'b1, 12'h100, $random(seed));
        apb_xfer(1'b0, 12'h042, 32'h0);              // misaligned
        apb_xfer(1'b1, 12'hFFC, $random(seed));

        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(1'b0, 8'($random(seed)), 8'($random(seed)),
                        8'(1 + ($unsigned($random(seed)) % 20)));
        end

        run_program(1'b1, 8'hFF, 8'($random(seed)) | 8'h01, 8'd12); // dark image
        run_program(1'b0, 8'h00, 8'h40, 8'd9);                       // full leak
        run_program(1'b0, 8'($random(seed)), 8'h00, 8'd7);           // fires each step

        // lockout while busy
        configure(8'hC0, 8'h30, 8'd20);
        apb_xfer(1'b1, snn_pkg::ADDR_CTRL, 32'h1);
        apb_xfer(1'b1, snn_pkg::ADDR_IMAGE + 12'h004, $random(seed));
        apb_xfer(1'b1, snn_pkg::ADDR_WEIGHT + 12'h008, $random(seed));
        configure(8'h11, 8'h22, 8'h33);
        apb_xfer(1'b1, snn_pkg::ADDR_CTRL, 32'h1);   // second start
        wait_idle();
        read_counts();
        read_back();

        // zero steps refused, then a restart clears done
        configure(8'h80, 8'h10, 8'd0);
        apb_xfer(1'b1, snn_pkg::ADDR_CTRL, 32'h1);
        apb_xfer(1'b0, snn_pkg::ADDR_STATUS, 32'h0);
        configure(8'h80, 8'h10, 8'd3);
        apb_xfer(1'b1, snn_pkg::ADDR_CTRL, 32'h1);
        wait_idle();
        read_counts();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // hard bound on run length
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < WATCHDOG_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles, run did not finish", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/snn_pkg.sv
logic/snn_apb_regs.sv
logic/snn_sequencer.sv
logic/spike_encoder.sv
logic/weight_store.sv
logic/lif_array.sv
logic/snn_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f --Mdir obj_dir -o tb_top
./obj_dir/tb_top > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
